/* list.f */
src/ex_pkg.sv
src/ex_alu.sv
src/ex_stage.sv
src/result_fifo.sv
src/commit_stage.sv
src/ex_top.sv
sim/tb_ex_top.sv

/* run.sh */
#!/bin/sh
# build and run the execute slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_ex_top -o tb_ex_top

out=$(./obj_dir/tb_ex_top) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi

/* sim/tb_ex_top.sv */
//////////////////////////////
// random ops checked against a reference model, in issue order
// stops at the first mismatch
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top
	import ex_pkg::*;
();

	localparam int CLK_PERIOD     = 8;
	localparam int N_ALU          = 160;
	localparam int N_CSR          = 32;
	localparam int N_WD           = 24;
	localparam int N_RAND         = 200;
	localparam int N_STALL        = 10;
	localparam int TOTAL_OPS      = N_ALU + N_CSR + N_WD + N_RAND + N_STALL;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * 20 + 200;

	// expected commit fields of one op
	typedef struct packed {
		logic      rd_wen;
		reg_idx_t  rd;
		xlen_t     rd_data;
		logic      csr_wen;
		csr_addr_t csr_addr;
		xlen_t     csr_wdata;
		xlen_t     mcause;
	} exp_t;

	logic        clock;
	logic        reset;
	logic        in_valid;
	logic        in_allowin;
	xlen_t       reg1, reg2, pc, imm, csr_rdata;
	alu_op_t     alu_op;
	src1_sel_t   src1_sel;
	src2_sel_t   src2_sel;
	csr_op_t     csr_op;
	csr_addr_t   csr_addr;
	logic        wd;
	reg_idx_t    rd;
	logic        fwd_valid, fwd_csr_valid;
	reg_idx_t    fwd_rd;
	xlen_t       fwd_data, fwd_csr_wdata;
	csr_addr_t   fwd_csr_addr;
	logic        commit_ready, commit_valid, commit_rd_wen, commit_csr_wen;
	reg_idx_t    commit_rd;
	xlen_t       commit_rd_data, commit_csr_wdata, commit_mcause;
	csr_addr_t   commit_csr_addr;
	retire_cnt_t retire_count;

	exp_t     exp_q[$];
	int       issued;
	// 0 ready high, 1 random, 2 held low
	logic [1:0] ready_mode;

	ex_top #(
		.DATA_LEN   (32),
		.FIFO_DEPTH (4)
	) uut (
		.clock              (clock),
		.reset              (reset),
		.in_valid_i         (in_valid),
		.in_allowin_o       (in_allowin),
		.reg1_i             (reg1),
		.reg2_i             (reg2),
		.pc_i               (pc),
		.imm_i              (imm),
		.alu_op_i           (alu_op),
		.src1_sel_i         (src1_sel),
		.src2_sel_i         (src2_sel),
		.csr_op_i           (csr_op),
		.csr_rdata_i        (csr_rdata),
		.csr_addr_i         (csr_addr),
		.wd_i               (wd),
		.rd_i               (rd),
		.fwd_valid_o        (fwd_valid),
		.fwd_rd_o           (fwd_rd),
		.fwd_data_o         (fwd_data),
		.fwd_csr_valid_o    (fwd_csr_valid),
		.fwd_csr_addr_o     (fwd_csr_addr),
		.fwd_csr_wdata_o    (fwd_csr_wdata),
		.commit_ready_i     (commit_ready),
		.commit_valid_o     (commit_valid),
		.commit_rd_wen_o    (commit_rd_wen),
		.commit_rd_o        (commit_rd),
		.commit_rd_data_o   (commit_rd_data),
		.commit_csr_wen_o   (commit_csr_wen),
		.commit_csr_addr_o  (commit_csr_addr),
		.commit_csr_wdata_o (commit_csr_wdata),
		.commit_mcause_o    (commit_mcause),
		.retire_count_o     (retire_count)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// expected result of one op, straight from the rv32 rules
	function automatic exp_t ref_execute(input xlen_t r1, input xlen_t r2, input xlen_t pcv,
		input xlen_t immv, input xlen_t old_csr, input alu_op_t op, input src1_sel_t s1,
		input src2_sel_t s2, input csr_op_t cop, input csr_addr_t caddr, input logic wdv,
		input reg_idx_t rdv);
		xlen_t      a;
		xlen_t      b;
		xlen_t      r;
		logic [4:0] sh;
		exp_t       e;
		case (s1)
			SRC1_ZERO: a = 32'd0;
			SRC1_REG1: a = r1;
			SRC1_PC:   a = pcv;
			default:   a = old_csr;
		endcase
		case (s2)
			SRC2_ZERO: b = 32'd0;
			SRC2_REG2: b = r2;
			SRC2_IMM:  b = immv;
			default:   b = 32'd4;
		endcase
		sh = b[4:0];
		case (op)
			ALU_ADD:  r = a + b;
			ALU_SUB:  r = a + ~b + 32'd1;
			ALU_XOR:  r = a ^ b;
			ALU_OR:   r = a | b;
			ALU_AND:  r = a & b;
			ALU_SRL:  r = a >> sh;
			// logical shift, then fill the vacated bits with the sign
			ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			ALU_SLL:  r = a << sh;
			ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
			// flipping the sign bits turns a signed compare into an unsigned one
			ALU_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
			default:  r = 32'd0;
		endcase
		e.rd_wen   = wdv && (rdv != 5'd0);
		e.rd       = rdv;
		e.rd_data  = r;
		e.csr_wen  = (cop != CSR_NONE);
		e.csr_addr = caddr;
		case (cop)
			CSR_CSRRW: e.csr_wdata = r1;
			CSR_CSRRS: e.csr_wdata = r1 | old_csr;
			CSR_ECALL: e.csr_wdata = pcv;
			default:   e.csr_wdata = 32'd0;
		endcase
		e.mcause = (cop == CSR_ECALL) ? MCAUSE_ECALL_M : 32'd0;
		return e;
	endfunction

	task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic check_csr_addr(input csr_addr_t got, input csr_addr_t exp,
		input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic check_count(input retire_cnt_t got, input retire_cnt_t exp,
		input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// forward port while the op sits in the stage
	task automatic check_fwd(input exp_t e);
		check_bit(fwd_valid, e.rd_wen, "fwd_valid_o");
		if (e.rd_wen) begin
			check_reg(fwd_rd, e.rd, "fwd_rd_o");
			check_word(fwd_data, e.rd_data, "fwd_data_o");
		end
		check_bit(fwd_csr_valid, e.csr_wen, "fwd_csr_valid_o");
		if (e.csr_wen) begin
			check_csr_addr(fwd_csr_addr, e.csr_addr, "fwd_csr_addr_o");
			check_word(fwd_csr_wdata, e.csr_wdata, "fwd_csr_wdata_o");
		end
	endtask

	// called at a falling edge, returns at the falling edge after the transfer
	task automatic drive_op(input alu_op_t op, input src1_sel_t s1, input src2_sel_t s2,
		input csr_op_t cop, input logic wdv, input reg_idx_t rdv, input int idle);
		exp_t e;
		in_valid = 1'b0;
		repeat (idle) @(negedge clock);
		reg1      = $urandom;
		reg2      = $urandom;
		pc        = $urandom & 32'hffff_fffc;
		imm       = $urandom;
		csr_rdata = $urandom;
		csr_addr  = 12'($urandom);
		alu_op    = op;
		src1_sel  = s1;
		src2_sel  = s2;
		csr_op    = cop;
		wd        = wdv;
		rd        = rdv;
		in_valid  = 1'b1;
		while (!in_allowin) @(negedge clock);
		e = ref_execute(reg1, reg2, pc, imm, csr_rdata, op, s1, s2, cop, csr_addr, wdv, rdv);
		exp_q.push_back(e);
		issued++;
		@(negedge clock);
		in_valid = 1'b0;
		check_fwd(e);
	endtask

	task automatic drive_random_op(input int idle);
		drive_op(alu_op_t'(4'($urandom_range(0, 9))), src1_sel_t'(2'($urandom_range(0, 3))),
			src2_sel_t'(2'($urandom_range(0, 3))), csr_op_t'(2'($urandom_range(0, 3))),
			1'($urandom_range(0, 1)), 5'($urandom_range(0, 31)), idle);
	endtask

	always @(negedge clock) begin
		if (ready_mode == 2'd1) begin
			commit_ready = 1'($urandom_range(0, 1));
		end else if (ready_mode == 2'd2) begin
			commit_ready = 1'b0;
		end else begin
			commit_ready = 1'b1;
		end
	end

	// commit transfers against the queue head, pre-edge values
	always @(posedge clock) begin : commit_compare
		exp_t e;
		if (!reset && commit_valid && commit_ready) begin
			if (exp_q.size() == 0) begin
				$display("a result was committed with no op outstanding at %0t ns", $time);
				$display("TEST RESULT: FAIL");
				$fatal(1, "unexpected commit");
			end else begin
				e = exp_q.pop_front();
				check_bit(commit_rd_wen, e.rd_wen, "commit_rd_wen_o");
				check_reg(commit_rd, e.rd, "commit_rd_o");
				check_word(commit_rd_data, e.rd_data, "commit_rd_data_o");
				check_bit(commit_csr_wen, e.csr_wen, "commit_csr_wen_o");
				if (e.csr_wen) begin
					check_csr_addr(commit_csr_addr, e.csr_addr, "commit_csr_addr_o");
					check_word(commit_csr_wdata, e.csr_wdata, "commit_csr_wdata_o");
				end
				check_word(commit_mcause, e.mcause, "commit_mcause_o");
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: the pipeline did not finish all ops in %0d cycles", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		int   i;
		int   j;
		int   k;
		logic saw_stall;
		void'($urandom(89));
		clock        = 1'b0;
		reset        = 1'b1;
		in_valid     = 1'b0;
		reg1         = '0;
		reg2         = '0;
		pc           = '0;
		imm          = '0;
		csr_rdata    = '0;
		alu_op       = ALU_ADD;
		src1_sel     = SRC1_ZERO;
		src2_sel     = SRC2_ZERO;
		csr_op       = CSR_NONE;
		csr_addr     = '0;
		wd           = 1'b0;
		rd           = '0;
		commit_ready = 1'b0;
		ready_mode   = 2'd0;
		issued       = 0;
		saw_stall    = 1'b0;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		// empty pipeline after reset
		check_bit(in_allowin, 1'b1, "in_allowin_o");
		check_bit(commit_valid, 1'b0, "commit_valid_o");
		check_bit(fwd_valid, 1'b0, "fwd_valid_o");
		check_bit(fwd_csr_valid, 1'b0, "fwd_csr_valid_o");
		check_count(retire_count, 32'd0, "retire_count_o");

		// every alu op against every source pair
		for (i = 0; i < 10; i++) begin
			for (j = 0; j < 4; j++) begin
				for (k = 0; k < 4; k++) begin
					drive_op(alu_op_t'(4'(i)), src1_sel_t'(2'(j)), src2_sel_t'(2'(k)), CSR_NONE,
						1'b1, 5'($urandom_range(1, 31)), 0);
				end
			end
		end

		for (i = 0; i < N_CSR; i++) begin
			drive_op(alu_op_t'(4'($urandom_range(0, 9))), src1_sel_t'(2'($urandom_range(0, 3))),
				src2_sel_t'(2'($urandom_range(0, 3))), csr_op_t'(2'(i % 4)), 1'b1,
				5'($urandom_range(0, 31)), 0);
		end

		// no write, or a write to x0
		for (i = 0; i < N_WD; i++) begin
			drive_op(alu_op_t'(4'($urandom_range(0, 9))), src1_sel_t'(2'($urandom_range(0, 3))),
				src2_sel_t'(2'($urandom_range(0, 3))), CSR_NONE, 1'(i % 2),
				(i % 2 == 0) ? 5'($urandom_range(1, 31)) : 5'd0, 0);
		end

		ready_mode = 2'd1;
		for (i = 0; i < N_RAND; i++) begin
			drive_random_op(($urandom_range(0, 1) == 1) ? 0 : int'($urandom_range(1, 3)));
		end

		// hold ready low until the back-pressure reaches the issue port
		ready_mode = 2'd2;
		for (i = 0; i < N_STALL && !saw_stall; i++) begin
			if (!in_allowin) begin
				saw_stall = 1'b1;
			end else begin
				drive_random_op(0);
			end
		end
		if (!saw_stall && in_allowin) begin
			$display("in_allowin_o stayed high while commit_ready_i was held low");
			$display("TEST RESULT: FAIL");
			$fatal(1, "no back-pressure at the issue port");
		end
		ready_mode = 2'd0;

		while (exp_q.size() != 0) @(negedge clock);
		@(negedge clock);
		check_count(retire_count, retire_cnt_t'(issued), "retire_count_o");
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src/commit_stage.sv */
//////////////////////////////
// single output register, rd writes to x0 are dropped here
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module commit_stage
	import ex_pkg::*;
(
	input  wire            clock,
	input  wire            reset,
	input  wire            in_valid_i,
	output logic           in_allowin_o,
	input  wire            in_wd_i,
	input  wire reg_idx_t  in_rd_i,
	input  wire xlen_t     in_result_i,
	input  wire            in_csr_wen_i,
	input  wire csr_addr_t in_csr_addr_i,
	input  wire xlen_t     in_csr_wdata_i,
	input  wire xlen_t     in_mcause_i,
	input  wire            commit_ready_i,
	output logic           commit_valid_o,
	output logic           commit_rd_wen_o,
	output reg_idx_t       commit_rd_o,
	output xlen_t          commit_rd_data_o,
	output logic           commit_csr_wen_o,
	output csr_addr_t      commit_csr_addr_o,
	output xlen_t          commit_csr_wdata_o,
	output xlen_t          commit_mcause_o,
	output retire_cnt_t    retire_count_o
);

	logic        cm_valid;
	logic        wd_q;
	retire_cnt_t retire_cnt;

	assign in_allowin_o = !cm_valid || commit_ready_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			cm_valid   <= 1'b0;
			retire_cnt <= '0;
		end else begin
			if (in_allowin_o) begin
				cm_valid <= in_valid_i;
			end
			// every handed-off op counts, x0 writes included
			if (cm_valid && commit_ready_i) begin
				retire_cnt <= retire_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid_i && in_allowin_o) begin
			wd_q               <= in_wd_i;
			commit_rd_o        <= in_rd_i;
			commit_rd_data_o   <= in_result_i;
			commit_csr_wen_o   <= in_csr_wen_i;
			commit_csr_addr_o  <= in_csr_addr_i;
			commit_csr_wdata_o <= in_csr_wdata_i;
			commit_mcause_o    <= in_mcause_i;
		end
	end

	assign commit_valid_o  = cm_valid;
	assign commit_rd_wen_o = wd_q && (commit_rd_o != '0);
	assign retire_count_o  = retire_cnt;

	a_hold_until_ready: assert property (@(posedge clock) disable iff (reset)
		(commit_valid_o && !commit_ready_i) |=> (commit_valid_o
			&& $stable(commit_rd_wen_o) && $stable(commit_rd_o)
			&& $stable(commit_rd_data_o) && $stable(commit_csr_wen_o)
			&& $stable(commit_csr_addr_o) && $stable(commit_csr_wdata_o)
			&& $stable(commit_mcause_o)));

endmodule

`default_nettype wire

/* src/ex_alu.sv */
//////////////////////////////
// purely combinational, unknown op codes give zero
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_alu
	import ex_pkg::*;
(
	input  wire xlen_t   src1_i,
	input  wire xlen_t   src2_i,
	input  wire alu_op_t op_i,
	output xlen_t        result_o
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// rv32 shifts only look at the low five bits
	assign shamt       = src2_i[4:0];
	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		result_o = '0;
		case (op_i)
			ALU_ADD: begin
				result_o = src1_i + src2_i;
			end
			ALU_SUB: begin
				result_o = src1_i - src2_i;
			end
			ALU_XOR:  result_o = src1_i ^ src2_i;
			ALU_OR:   result_o = src1_i | src2_i;
			ALU_AND:  result_o = src1_i & src2_i;
			ALU_SRL:  result_o = src1_i >> shamt;
			ALU_SRA: begin
				result_o = xlen_t'($signed(src1_i) >>> shamt);
			end
			ALU_SLL:  result_o = src1_i << shamt;
			// compares return 0 or 1
			ALU_SLTU: result_o = {31'b0, lt_unsigned};
			ALU_SLT:  result_o = {31'b0, lt_signed};
			default:  result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/ex_pkg.sv */
//////////////////////////////
// shared types for the execute slice
// widths are fixed at RV32, csr ops limited to csrrw/csrrs/ecall
//////////////////////////////
`default_nettype none

package ex_pkg;

	// data word, used for operands, pc, immediate and results
	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [31:0] retire_cnt_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_XOR  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_AND  = 4'd4,
		ALU_SRL  = 4'd5,
		ALU_SRA  = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SLTU = 4'd8,
		ALU_SLT  = 4'd9
	} alu_op_t;

	// first alu source
	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2,
		SRC1_CSR  = 2'd3
	} src1_sel_t;

	// second alu source
	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_REG2 = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3
	} src2_sel_t;

	typedef enum logic [1:0] {
		CSR_NONE  = 2'd0,
		CSR_CSRRW = 2'd1,
		CSR_CSRRS = 2'd2,
		CSR_ECALL = 2'd3
	} csr_op_t;

	// mcause for an environment call from m-mode
	localparam xlen_t MCAUSE_ECALL_M = 32'd11;

endpackage

`default_nettype wire

/* src/ex_stage.sv */
//////////////////////////////
// one op deep, never stalls on its own
// DATA_LEN must match xlen_t
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_stage
	import ex_pkg::*;
#(
	parameter int DATA_LEN = 32
) (
	input  wire            clock,
	input  wire            reset,
	input  wire            in_valid_i,
	output logic           in_allowin_o,
	input  wire xlen_t     reg1_i,
	input  wire xlen_t     reg2_i,
	input  wire xlen_t     pc_i,
	input  wire xlen_t     imm_i,
	input  wire alu_op_t   alu_op_i,
	input  wire src1_sel_t src1_sel_i,
	input  wire src2_sel_t src2_sel_i,
	input  wire csr_op_t   csr_op_i,
	input  wire xlen_t     csr_rdata_i,
	input  wire csr_addr_t csr_addr_i,
	input  wire            wd_i,
	input  wire reg_idx_t  rd_i,
	input  wire            out_allowin_i,
	output logic           out_valid_o,
	output logic           out_wd_o,
	output reg_idx_t       out_rd_o,
	output xlen_t          out_result_o,
	output logic           out_csr_wen_o,
	output csr_addr_t      out_csr_addr_o,
	output xlen_t          out_csr_wdata_o,
	output xlen_t          out_mcause_o,
	output logic           fwd_valid_o,
	output reg_idx_t       fwd_rd_o,
	output xlen_t          fwd_data_o,
	output logic           fwd_csr_valid_o,
	output csr_addr_t      fwd_csr_addr_o,
	output xlen_t          fwd_csr_wdata_o
);

	logic      es_valid;
	xlen_t     reg1_q, reg2_q, pc_q, imm_q, csr_rdata_q;
	alu_op_t   alu_op_q;
	src1_sel_t src1_sel_q;
	src2_sel_t src2_sel_q;
	csr_op_t   csr_op_q;
	csr_addr_t csr_addr_q;
	logic      wd_q;
	reg_idx_t  rd_q;

	logic [DATA_LEN-1:0] src1;
	logic [DATA_LEN-1:0] src2;
	logic [DATA_LEN-1:0] csr_wdata;
	xlen_t               alu_result;
	logic                csr_wen;

	// empty, or the held op leaves this cycle
	assign in_allowin_o = !es_valid || out_allowin_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			es_valid <= 1'b0;
		end else if (in_allowin_o) begin
			es_valid <= in_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid_i && in_allowin_o) begin
			reg1_q      <= reg1_i;
			reg2_q      <= reg2_i;
			pc_q        <= pc_i;
			imm_q       <= imm_i;
			alu_op_q    <= alu_op_i;
			src1_sel_q  <= src1_sel_i;
			src2_sel_q  <= src2_sel_i;
			csr_op_q    <= csr_op_i;
			csr_rdata_q <= csr_rdata_i;
			csr_addr_q  <= csr_addr_i;
			wd_q        <= wd_i;
			rd_q        <= rd_i;
		end
	end

	always_comb begin
		src1 = '0;
		case (src1_sel_q)
			SRC1_ZERO: src1 = '0;
			SRC1_REG1: src1 = reg1_q;
			SRC1_PC:   src1 = pc_q;
			SRC1_CSR:  src1 = csr_rdata_q;
		endcase
	end

	always_comb begin
		src2 = '0;
		case (src2_sel_q)
			SRC2_ZERO: src2 = '0;
			SRC2_REG2: src2 = reg2_q;
			SRC2_IMM:  src2 = imm_q;
			SRC2_FOUR: src2 = 32'd4;
		endcase
	end

	ex_alu u_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.op_i     (alu_op_q),
		.result_o (alu_result)
	);

	// ecall writes the trapping pc into mepc
	always_comb begin
		csr_wdata = '0;
		case (csr_op_q)
			CSR_CSRRW: csr_wdata = reg1_q;
			CSR_CSRRS: csr_wdata = reg1_q | csr_rdata_q;
			CSR_ECALL: csr_wdata = pc_q;
			default:   csr_wdata = '0;
		endcase
	end

	assign csr_wen = (csr_op_q != CSR_NONE);

	assign out_valid_o     = es_valid;
	assign out_wd_o        = wd_q;
	assign out_rd_o        = rd_q;
	assign out_result_o    = alu_result;
	assign out_csr_wen_o   = csr_wen;
	assign out_csr_addr_o  = csr_addr_q;
	assign out_csr_wdata_o = csr_wdata;
	assign out_mcause_o    = (csr_op_q == CSR_ECALL) ? MCAUSE_ECALL_M : '0;

	// forward toward decode, x0 never forwards
	assign fwd_valid_o     = es_valid && wd_q && (rd_q != '0);
	assign fwd_rd_o        = rd_q;
	assign fwd_data_o      = alu_result;
	assign fwd_csr_valid_o = es_valid && csr_wen;
	assign fwd_csr_addr_o  = csr_addr_q;
	assign fwd_csr_wdata_o = csr_wdata;

	a_empty_after_reset: assert property (@(posedge clock) reset |=> !out_valid_o);

endmodule

`default_nettype wire

/* src/ex_top.sv */
//////////////////////////////
// execute, result buffer, commit
// no loads, stores or branches
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_top
	import ex_pkg::*;
#(
	parameter int DATA_LEN   = 32,
	parameter int FIFO_DEPTH = 4
) (
	input  wire            clock,
	input  wire            reset,
	input  wire            in_valid_i,
	output logic           in_allowin_o,
	input  wire xlen_t     reg1_i,
	input  wire xlen_t     reg2_i,
	input  wire xlen_t     pc_i,
	input  wire xlen_t     imm_i,
	input  wire alu_op_t   alu_op_i,
	input  wire src1_sel_t src1_sel_i,
	input  wire src2_sel_t src2_sel_i,
	input  wire csr_op_t   csr_op_i,
	input  wire xlen_t     csr_rdata_i,
	input  wire csr_addr_t csr_addr_i,
	input  wire            wd_i,
	input  wire reg_idx_t  rd_i,
	output logic           fwd_valid_o,
	output reg_idx_t       fwd_rd_o,
	output xlen_t          fwd_data_o,
	output logic           fwd_csr_valid_o,
	output csr_addr_t      fwd_csr_addr_o,
	output xlen_t          fwd_csr_wdata_o,
	input  wire            commit_ready_i,
	output logic           commit_valid_o,
	output logic           commit_rd_wen_o,
	output reg_idx_t       commit_rd_o,
	output xlen_t          commit_rd_data_o,
	output logic           commit_csr_wen_o,
	output csr_addr_t      commit_csr_addr_o,
	output xlen_t          commit_csr_wdata_o,
	output xlen_t          commit_mcause_o,
	output retire_cnt_t    retire_count_o
);

	// stage to buffer
	logic      es_valid, es_wd, es_csr_wen, fifo_allowin;
	reg_idx_t  es_rd;
	xlen_t     es_result, es_csr_wdata, es_mcause;
	csr_addr_t es_csr_addr;

	// buffer head to commit
	logic      fifo_valid, fifo_wd, fifo_csr_wen, cm_allowin;
	reg_idx_t  fifo_rd;
	xlen_t     fifo_result, fifo_csr_wdata, fifo_mcause;
	csr_addr_t fifo_csr_addr;

	ex_stage #(
		.DATA_LEN (DATA_LEN)
	) u_ex_stage (
		.clock           (clock),
		.reset           (reset),
		.in_valid_i      (in_valid_i),
		.in_allowin_o    (in_allowin_o),
		.reg1_i          (reg1_i),
		.reg2_i          (reg2_i),
		.pc_i            (pc_i),
		.imm_i           (imm_i),
		.alu_op_i        (alu_op_i),
		.src1_sel_i      (src1_sel_i),
		.src2_sel_i      (src2_sel_i),
		.csr_op_i        (csr_op_i),
		.csr_rdata_i     (csr_rdata_i),
		.csr_addr_i      (csr_addr_i),
		.wd_i            (wd_i),
		.rd_i            (rd_i),
		.out_allowin_i   (fifo_allowin),
		.out_valid_o     (es_valid),
		.out_wd_o        (es_wd),
		.out_rd_o        (es_rd),
		.out_result_o    (es_result),
		.out_csr_wen_o   (es_csr_wen),
		.out_csr_addr_o  (es_csr_addr),
		.out_csr_wdata_o (es_csr_wdata),
		.out_mcause_o    (es_mcause),
		.fwd_valid_o     (fwd_valid_o),
		.fwd_rd_o        (fwd_rd_o),
		.fwd_data_o      (fwd_data_o),
		.fwd_csr_valid_o (fwd_csr_valid_o),
		.fwd_csr_addr_o  (fwd_csr_addr_o),
		.fwd_csr_wdata_o (fwd_csr_wdata_o)
	);

	result_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_result_fifo (
		.clock           (clock),
		.reset           (reset),
		.push_valid_i    (es_valid),
		.push_allowin_o  (fifo_allowin),
		.in_wd_i         (es_wd),
		.in_rd_i         (es_rd),
		.in_result_i     (es_result),
		.in_csr_wen_i    (es_csr_wen),
		.in_csr_addr_i   (es_csr_addr),
		.in_csr_wdata_i  (es_csr_wdata),
		.in_mcause_i     (es_mcause),
		.pop_valid_o     (fifo_valid),
		.pop_allowin_i   (cm_allowin),
		.out_wd_o        (fifo_wd),
		.out_rd_o        (fifo_rd),
		.out_result_o    (fifo_result),
		.out_csr_wen_o   (fifo_csr_wen),
		.out_csr_addr_o  (fifo_csr_addr),
		.out_csr_wdata_o (fifo_csr_wdata),
		.out_mcause_o    (fifo_mcause)
	);

	commit_stage u_commit_stage (
		.clock              (clock),
		.reset              (reset),
		.in_valid_i         (fifo_valid),
		.in_allowin_o       (cm_allowin),
		.in_wd_i            (fifo_wd),
		.in_rd_i            (fifo_rd),
		.in_result_i        (fifo_result),
		.in_csr_wen_i       (fifo_csr_wen),
		.in_csr_addr_i      (fifo_csr_addr),
		.in_csr_wdata_i     (fifo_csr_wdata),
		.in_mcause_i        (fifo_mcause),
		.commit_ready_i     (commit_ready_i),
		.commit_valid_o     (commit_valid_o),
		.commit_rd_wen_o    (commit_rd_wen_o),
		.commit_rd_o        (commit_rd_o),
		.commit_rd_data_o   (commit_rd_data_o),
		.commit_csr_wen_o   (commit_csr_wen_o),
		.commit_csr_addr_o  (commit_csr_addr_o),
		.commit_csr_wdata_o (commit_csr_wdata_o),
		.commit_mcause_o    (commit_mcause_o),
		.retire_count_o     (retire_count_o)
	);

endmodule

`default_nettype wire

/* src/result_fifo.sv */
//////////////////////////////
// DEPTH must be a power of two and at least 2
// head entry is read without a register stage
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module result_fifo
	import ex_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  wire            clock,
	input  wire            reset,
	input  wire            push_valid_i,
	output logic           push_allowin_o,
	input  wire            in_wd_i,
	input  wire reg_idx_t  in_rd_i,
	input  wire xlen_t     in_result_i,
	input  wire            in_csr_wen_i,
	input  wire csr_addr_t in_csr_addr_i,
	input  wire xlen_t     in_csr_wdata_i,
	input  wire xlen_t     in_mcause_i,
	output logic           pop_valid_o,
	input  wire            pop_allowin_i,
	output logic           out_wd_o,
	output reg_idx_t       out_rd_o,
	output xlen_t          out_result_o,
	output logic           out_csr_wen_o,
	output csr_addr_t      out_csr_addr_o,
	output xlen_t          out_csr_wdata_o,
	output xlen_t          out_mcause_o
);

	localparam int AW = $clog2(DEPTH);

	logic      wd_mem        [DEPTH];
	reg_idx_t  rd_mem        [DEPTH];
	xlen_t     result_mem    [DEPTH];
	logic      csr_wen_mem   [DEPTH];
	csr_addr_t csr_addr_mem  [DEPTH];
	xlen_t     csr_wdata_mem [DEPTH];
	xlen_t     mcause_mem    [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign push_allowin_o = (count != (AW+1)'(DEPTH));
	assign pop_valid_o    = (count != '0);
	assign do_push        = push_valid_i && push_allowin_o;
	assign do_pop         = pop_valid_o && pop_allowin_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			wd_mem[wr_ptr]        <= in_wd_i;
			rd_mem[wr_ptr]        <= in_rd_i;
			result_mem[wr_ptr]    <= in_result_i;
			csr_wen_mem[wr_ptr]   <= in_csr_wen_i;
			csr_addr_mem[wr_ptr]  <= in_csr_addr_i;
			csr_wdata_mem[wr_ptr] <= in_csr_wdata_i;
			mcause_mem[wr_ptr]    <= in_mcause_i;
		end
	end

	assign out_wd_o        = wd_mem[rd_ptr];
	assign out_rd_o        = rd_mem[rd_ptr];
	assign out_result_o    = result_mem[rd_ptr];
	assign out_csr_wen_o   = csr_wen_mem[rd_ptr];
	assign out_csr_addr_o  = csr_addr_mem[rd_ptr];
	assign out_csr_wdata_o = csr_wdata_mem[rd_ptr];
	assign out_mcause_o    = mcause_mem[rd_ptr];

	// occupancy never goes past DEPTH
	a_no_push_full: assert property (@(posedge clock) disable iff (reset)
		count <= (AW+1)'(DEPTH));

	// pointer distance always equals the count
	a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
		(wr_ptr - rd_ptr) == count[AW-1:0]);

endmodule

`default_nettype wire
